// File: src/ps2_kbd_pkg.sv
`default_nettype none

package ps2_kbd_pkg;

    // One byte as it comes off the keyboard.
    typedef logic [7:0] scan_t;

    // Active-low pattern of one seven-segment digit; a lit segment is 0.
    typedef logic [6:0] seg7_t;

    // Prefix sent before the code of a released key.
    localparam scan_t PS2_BREAK = 8'hF0;

    // Prefix of the extended keys (arrows, right Ctrl and so on).
    localparam scan_t PS2_EXT = 8'hE0;

    // Start bit, eight data bits LSB first, odd parity, stop bit.
    localparam int PS2_FRAME_BITS = 11;

endpackage

`default_nettype wire

// File: src/ps2_rx.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_rx import ps2_kbd_pkg::*; #(
    parameter int SYNC_STAGES = 3
) (
    input  wire   clk,
    input  wire   rst,
    input  wire   ps2_clk,
    input  wire   ps2_data,
    output scan_t code,
    output logic  code_valid,
    output logic  frame_error
);

    localparam int CNT_W = $clog2(PS2_FRAME_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(PS2_FRAME_BITS - 1);

    logic [SYNC_STAGES-1:0]    clk_sync;
    logic [SYNC_STAGES-1:0]    data_sync;
    logic                      clk_prev;
    logic                      fall;
    logic [PS2_FRAME_BITS-1:0] frame;
    logic [CNT_W-1:0]          bit_cnt;
    logic                      frame_done;
    logic                      frame_ok;

    // Both lines idle high, so the synchronizers start at one.
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            data_sync <= {data_sync[SYNC_STAGES-2:0], ps2_data};
            clk_prev  <= clk_sync[SYNC_STAGES-1];
        end
    end

    assign fall = clk_prev & ~clk_sync[SYNC_STAGES-1];

    // Bits arrive LSB first, so they enter at the top and move down.
    always_ff @(posedge clk) begin
        if (fall) begin
            frame <= {data_sync[SYNC_STAGES-1], frame[PS2_FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (fall) begin
                if (bit_cnt == LAST_BIT) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1; // Frame register is complete next cycle.
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Start low, odd parity over data and parity bit, stop high.
    assign frame_ok = ~frame[0]
                    & (^frame[PS2_FRAME_BITS-2:1])
                    & frame[PS2_FRAME_BITS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid  <= frame_done & frame_ok;
            frame_error <= frame_done & ~frame_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done) begin
            code <= frame[8:1];
        end
    end

endmodule

`default_nettype wire

// File: src/key_filter.sv
`timescale 1ns/100ps
`default_nettype none

module key_filter import ps2_kbd_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire scan_t code,
    input  wire        code_valid,
    output logic       push,
    output scan_t      push_code,
    output logic [7:0] press_count
);

    logic  release_armed; // An F0 was seen, the next byte names the released key.
    logic  last_released;

    always_ff @(posedge clk) begin
        if (rst) begin
            push          <= 1'b0;
            press_count   <= 8'd0;
            release_armed <= 1'b0;
            last_released <= 1'b1; // So the first key after reset counts.
        end else begin
            push <= 1'b0;
            if (code_valid) begin
                if (code == PS2_EXT) begin
                    // Extended keys then arrive as their base code.
                end else if (code == PS2_BREAK) begin
                    release_armed <= 1'b1;
                end else if (release_armed) begin
                    release_armed <= 1'b0;
                    if (code == push_code) begin
                        last_released <= 1'b1;
                    end
                end else begin
                    push          <= 1'b1;
                    last_released <= 1'b0;
                    // Typematic repeats carry the same code without a release.
                    if (code != push_code || last_released) begin
                        press_count <= press_count + 8'd1;
                    end
                end
            end
        end
    end

    // Payload follows the make code that is pushed.
    always_ff @(posedge clk) begin
        if (code_valid && code != PS2_EXT && code != PS2_BREAK && !release_armed) begin
            push_code <= code;
        end
    end

endmodule

`default_nettype wire

// File: src/key_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module key_fifo import ps2_kbd_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        push,
    input  wire scan_t push_code,
    input  wire        next,
    output scan_t      head,
    output logic       ready,
    output logic       overflow
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    scan_t           mem [FIFO_DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            empty;
    logic            full;
    logic            do_push;
    logic            do_pop;

    // The extra pointer bit tells a full queue from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
                && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign do_push = push & ~full;
    assign do_pop  = next & ~empty; // A pop on an empty queue is ignored.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && full) begin
                overflow <= 1'b1; // Held until reset.
            end
        end
    end

    assign head  = mem[rd_ptr[ADDR_W-1:0]];
    assign ready = ~empty;

endmodule

`default_nettype wire

// File: src/scan_ascii.sv
`timescale 1ns/100ps
`default_nettype none

module scan_ascii import ps2_kbd_pkg::*; (
    input  wire scan_t code,
    output logic [7:0] ascii
);

    // Set-2 make codes; letters come out in upper case.
    always_comb begin
        case (code)
            8'h1C: ascii = 8'h41; // A
            8'h32: ascii = 8'h42;
            8'h21: ascii = 8'h43;
            8'h23: ascii = 8'h44;
            8'h24: ascii = 8'h45;
            8'h2B: ascii = 8'h46;
            8'h34: ascii = 8'h47;
            8'h33: ascii = 8'h48;
            8'h43: ascii = 8'h49;
            8'h3B: ascii = 8'h4A;
            8'h42: ascii = 8'h4B;
            8'h4B: ascii = 8'h4C;
            8'h3A: ascii = 8'h4D;
            8'h31: ascii = 8'h4E;
            8'h44: ascii = 8'h4F;
            8'h4D: ascii = 8'h50;
            8'h15: ascii = 8'h51;
            8'h2D: ascii = 8'h52;
            8'h1B: ascii = 8'h53;
            8'h2C: ascii = 8'h54;
            8'h3C: ascii = 8'h55;
            8'h2A: ascii = 8'h56;
            8'h1D: ascii = 8'h57;
            8'h22: ascii = 8'h58;
            8'h35: ascii = 8'h59;
            8'h1A: ascii = 8'h5A; // Z
            8'h45: ascii = 8'h30; // Digit row, 0 first.
            8'h16: ascii = 8'h31;
            8'h1E: ascii = 8'h32;
            8'h26: ascii = 8'h33;
            8'h25: ascii = 8'h34;
            8'h2E: ascii = 8'h35;
            8'h36: ascii = 8'h36;
            8'h3D: ascii = 8'h37;
            8'h3E: ascii = 8'h38;
            8'h46: ascii = 8'h39;
            8'h29: ascii = 8'h20; // Space.
            8'h5A: ascii = 8'h0D; // Enter.
            8'h66: ascii = 8'h08; // Backspace.
            default: ascii = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: src/seg7_display.sv
`timescale 1ns/100ps
`default_nettype none

module seg7_display import ps2_kbd_pkg::*; (
    input  wire scan_t head,
    input  wire [7:0]  ascii,
    input  wire        ready,
    input  wire [7:0]  press_count,
    output seg7_t      seg0,
    output seg7_t      seg1,
    output seg7_t      seg2,
    output seg7_t      seg3,
    output seg7_t      seg4,
    output seg7_t      seg5
);

    localparam seg7_t BLANK = 7'b1111111;

    logic [7:0] count_mod;
    logic [3:0] tens;
    logic [3:0] units;

    // One table serves the hex and the decimal digits.
    function automatic seg7_t digit_seg(input logic [3:0] value);
        seg7_t seg;
        case (value)
            4'h0: seg = 7'b0000001;
            4'h1: seg = 7'b1001111;
            4'h2: seg = 7'b0010010;
            4'h3: seg = 7'b0000110;
            4'h4: seg = 7'b1001100;
            4'h5: seg = 7'b0100100;
            4'h6: seg = 7'b0100000;
            4'h7: seg = 7'b0001111;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0000100;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b1100000; // Lower case b, so it differs from 8.
            4'hC: seg = 7'b0110001;
            4'hD: seg = 7'b1000010; // Lower case d.
            4'hE: seg = 7'b0110000;
            default: seg = 7'b0111000;
        endcase
        return seg;
    endfunction

    // Only the last two decimal digits of the count fit on the display.
    assign count_mod = press_count % 8'd100;
    assign tens      = 4'(count_mod / 8'd10);
    assign units     = 4'(count_mod % 8'd10);

    // Code and ASCII digits are dark while the queue is empty.
    assign seg0 = ready ? digit_seg(head[3:0])  : BLANK;
    assign seg1 = ready ? digit_seg(head[7:4])  : BLANK;
    assign seg2 = ready ? digit_seg(ascii[3:0]) : BLANK;
    assign seg3 = ready ? digit_seg(ascii[7:4]) : BLANK;

    assign seg4 = digit_seg(units);
    assign seg5 = digit_seg(tens);

endmodule

`default_nettype wire

// File: src/ps2_kbd_display.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_kbd_display import ps2_kbd_pkg::*; #(
    parameter int FIFO_DEPTH  = 8,
    parameter int SYNC_STAGES = 3
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    input  wire        next,
    output scan_t      data,
    output logic [7:0] ascii,
    output logic       ready,
    output logic       overflow,
    output logic       frame_error,
    output seg7_t      seg0,
    output seg7_t      seg1,
    output seg7_t      seg2,
    output seg7_t      seg3,
    output seg7_t      seg4,
    output seg7_t      seg5
);

    scan_t      code;
    logic       code_valid;
    logic       push;
    scan_t      push_code;
    logic [7:0] press_count;

    ps2_rx #(
        .SYNC_STAGES (SYNC_STAGES)
    ) rx_i (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .code        (code),
        .code_valid  (code_valid),
        .frame_error (frame_error)
    );

    key_filter filter_i (
        .clk         (clk),
        .rst         (rst),
        .code        (code),
        .code_valid  (code_valid),
        .push        (push),
        .push_code   (push_code),
        .press_count (press_count)
    );

    // The queue head is both the data output and the display source.
    key_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_code (push_code),
        .next      (next),
        .head      (data),
        .ready     (ready),
        .overflow  (overflow)
    );

    scan_ascii ascii_i (
        .code  (data),
        .ascii (ascii)
    );

    seg7_display display_i (
        .head        (data),
        .ascii       (ascii),
        .ready       (ready),
        .press_count (press_count),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .seg4        (seg4),
        .seg5        (seg5)
    );

endmodule

`default_nettype wire

// File: verification/ps2_kbd_display_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_kbd_display_tb import ps2_kbd_pkg::*; ();

    localparam int    HALF_BIT  = 20;  // Half-period of ps2_clk in clk cycles.
    localparam int    TIMEOUT   = 200;
    localparam string TEST_FILE = "verification/ps2_kbd_tests.txt";

    // Active-low digit patterns, segment a in the top bit.
    localparam seg7_t DIGIT_SEG [16] = '{
        7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110,
        7'b1001100, 7'b0100100, 7'b0100000, 7'b0001111,
        7'b0000000, 7'b0000100, 7'b0001000, 7'b1100000,
        7'b0110001, 7'b1000010, 7'b0110000, 7'b0111000
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic       next;
    scan_t      data;
    logic [7:0] ascii;
    logic       ready;
    logic       overflow;
    logic       frame_error;
    seg7_t      seg0;
    seg7_t      seg1;
    seg7_t      seg2;
    seg7_t      seg3;
    seg7_t      seg4;
    seg7_t      seg5;

    int checks       = 0;
    int mismatches   = 0;
    int failures     = 0;
    int error_pulses = 0;

    ps2_kbd_display #(
        .FIFO_DEPTH  (8),
        .SYNC_STAGES (3)
    ) ps2_kbd_display_i (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .next        (next),
        .data        (data),
        .ascii       (ascii),
        .ready       (ready),
        .overflow    (overflow),
        .frame_error (frame_error),
        .seg0        (seg0),
        .seg1        (seg1),
        .seg2        (seg2),
        .seg3        (seg3),
        .seg4        (seg4),
        .seg5        (seg5)
    );

    always #2 clk = ~clk;

    // Inputs change and outputs are read 1 ns after the rising edge.
    task automatic step();
        @(posedge clk);
        #1;
        if (frame_error) begin
            error_pulses++; // One-cycle pulse, seen once per step.
        end
    endtask

    task automatic check(input string what, input logic [7:0] expected, input logic [7:0] actual);
        checks++;
        if (expected !== actual) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic send_frame(input scan_t value, input logic bad_parity);
        logic [PS2_FRAME_BITS-1:0] bits;
        bits = {1'b1, ~(^value) ^ bad_parity, value, 1'b0}; // Stop, parity, data, start.
        for (int i = 0; i < PS2_FRAME_BITS; i++) begin
            ps2_data = bits[i];
            repeat (HALF_BIT) step();
            ps2_clk = 1'b0;
            repeat (HALF_BIT) step();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (HALF_BIT) step();
    endtask

    task automatic expect_ready(input string name, input logic level);
        int waited;
        waited = 0;
        if (level) begin
            while (ready !== 1'b1 && waited < TIMEOUT) begin
                step();
                waited++;
            end
            if (ready !== 1'b1) begin
                failures++;
                $display("Timeout in %s: ready did not rise within %0d cycles", name, TIMEOUT);
            end
        end else begin
            // An empty queue has to stay empty for the whole window.
            while (ready === 1'b0 && waited < TIMEOUT) begin
                step();
                waited++;
            end
            check({name, " ready"}, 8'h00, 8'(ready));
            check({name, " seg0"}, 8'h7F, 8'(seg0));
            check({name, " seg1"}, 8'h7F, 8'(seg1));
            check({name, " seg2"}, 8'h7F, 8'(seg2));
            check({name, " seg3"}, 8'h7F, 8'(seg3));
        end
    endtask

    task automatic pop_entry(input string name, input scan_t code, input logic [7:0] exp_ascii);
        expect_ready(name, 1'b1);
        check({name, " data"}, code, data);
        check({name, " ascii"}, exp_ascii, ascii);
        check({name, " seg0"}, 8'(DIGIT_SEG[code[3:0]]), 8'(seg0));
        check({name, " seg1"}, 8'(DIGIT_SEG[code[7:4]]), 8'(seg1));
        check({name, " seg2"}, 8'(DIGIT_SEG[exp_ascii[3:0]]), 8'(seg2));
        check({name, " seg3"}, 8'(DIGIT_SEG[exp_ascii[7:4]]), 8'(seg3));
        next = 1'b1;
        step();
        next = 1'b0;
    endtask

    task automatic run_test(input string op, input string name, input scan_t stim,
                            input logic [7:0] expv);
        int   pulses_before;
        logic bad;
        pulses_before = error_pulses;
        bad = (op == "sendbad");
        if (op == "send" || op == "sendbad") begin
            send_frame(stim, bad);
            check({name, " frame_error"}, {7'd0, bad}, 8'(error_pulses - pulses_before));
            expect_ready(name, expv[0]);
        end else if (op == "pop") begin
            pop_entry(name, stim, expv);
        end else if (op == "count") begin
            check({name, " seg4"}, 8'(DIGIT_SEG[expv[3:0]]), 8'(seg4)); // Units.
            check({name, " seg5"}, 8'(DIGIT_SEG[expv[7:4]]), 8'(seg5));
        end else if (op == "ovf") begin
            check({name, " overflow"}, expv, 8'(overflow));
        end else begin
            failures++;
            $display("Unknown operation %s in test %s", op, name);
        end
    endtask

    initial begin : main
        int         fd;
        int         fields;
        string      line;
        string      op;
        string      name;
        logic [7:0] stim;
        logic [7:0] expv;
        rst      = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        next     = 1'b0;
        repeat (10) step();
        rst = 1'b0;
        step();
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the test file %s", TEST_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %s %h %h", op, name, stim, expv);
                if (fields != 4) begin
                    failures++;
                    $display("Could not read a test line: %s", line);
                end else begin
                    run_test(op, name, stim, expv);
                end
            end
            $fclose(fd);
        end
        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0 && checks > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ps2_kbd_display.f
src/ps2_kbd_pkg.sv
src/ps2_rx.sv
src/key_filter.sv
src/key_fifo.sv
src/scan_ascii.sv
src/seg7_display.sv
src/ps2_kbd_display.sv
verification/ps2_kbd_display_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ps2_kbd_display_tb
FILELIST  ?= ps2_kbd_display.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, FILELIST, BUILD_DIR, VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/ps2_kbd_tests.txt
# op name byte expected, byte and expected in hex.
# send/sendbad expect ready after the frame, pop gives data and ascii, count gives two decimal digits.
count   reset_count  00 00
ovf     reset_ovf    00 00
send    a_make       1C 01
pop     a_pop        1C 41
send    zero_make    45 01
pop     zero_pop     45 30
count   two_keys     00 02
send    pfx_a        1C 01
send    pfx_brk_a    F0 01
send    pfx_rel_a    1C 01
send    pfx_ext      E0 01
send    pfx_kp8      75 01
send    pfx_brk_kp8  F0 01
send    pfx_rel_kp8  75 01
pop     pfx_pop_a    1C 41
pop     pfx_pop_kp8  75 00
sendbad bad_parity   1C 00
send    rep_first    1C 01
send    rep_again    1C 01
send    rep_third    1C 01
count   rep_one      00 05
send    rep_brk      F0 01
send    rep_rel      1C 01
send    rep_new      1C 01
count   rep_two      00 06
pop     rep_pop1     1C 41
pop     rep_pop2     1C 41
pop     rep_pop3     1C 41
pop     rep_pop4     1C 41
send    fill_1       16 01
send    fill_2       1E 01
send    fill_3       26 01
send    fill_4       25 01
send    fill_5       2E 01
send    fill_6       36 01
send    fill_7       3D 01
send    fill_8       3E 01
send    fill_9       46 01
ovf     ovf_set      00 01
pop     drain_1      16 31
pop     drain_2      1E 32
pop     drain_3      26 33
pop     drain_4      25 34
pop     drain_5      2E 35
pop     drain_6      36 36
pop     drain_7      3D 37
pop     drain_8      3E 38
count   fill_count   00 15
sendbad drain_empty  00 00
